// ==== logic/reg_bus_pkg.sv ====
`default_nettype none

package reg_bus_pkg;

    // byte address and register word
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;

    // word index inside a region, addr[5:2]
    typedef logic [3:0] reg_idx_t;
    // region number, addr[15:12]
    typedef logic [3:0] region_t;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    localparam region_t REGION_0 = 4'd0;
    localparam region_t REGION_1 = 4'd1;

    // native request, 50 bits
    typedef struct packed {
        addr_t addr;
        logic  wr_en;
        logic  rd_en;
        data_t wr_data;
    } reg_req_t;

    // native response, 33 bits
    typedef struct packed {
        data_t rd_data;
        logic  err;
    } reg_rsp_t;

    function automatic region_t addr_region(addr_t addr);
        return addr[15:12];
    endfunction

    function automatic reg_idx_t addr_index(addr_t addr);
        return addr[5:2];
    endfunction

endpackage

`default_nettype wire

// ==== logic/axil_reg_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_reg_bridge (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire reg_bus_pkg::addr_t     awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire reg_bus_pkg::data_t     wdata,
    input  wire                         wvalid,
    output logic                        wready,
    output reg_bus_pkg::axi_resp_t      bresp,
    output logic                        bvalid,
    input  wire                         bready,
    input  wire reg_bus_pkg::addr_t     araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output reg_bus_pkg::data_t          rdata,
    output reg_bus_pkg::axi_resp_t      rresp,
    output logic                        rvalid,
    input  wire                         rready,
    output reg_bus_pkg::reg_req_t       req,
    output logic                        req_vld,
    input  wire reg_bus_pkg::reg_rsp_t  rsp,
    input  wire                         ack_vld
);
    import reg_bus_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_RESP
    } state_t;

    state_t    state;
    state_t    next_state;
    reg_req_t  req_q;
    data_t     rdata_q;
    axi_resp_t resp_q;
    logic      wr_go;
    logic      rd_go;
    logic      done;

    // a complete write wins over a waiting read
    assign wr_go = (state == S_IDLE) && awvalid && wvalid;
    assign rd_go = (state == S_IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    // response taken on the channel that matches the held access
    assign done = req_q.wr_en ? bready : rready;

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (wr_go || rd_go) begin
                    next_state = S_REQ;
                end
            end
            S_REQ:  next_state = S_WAIT;
            S_WAIT: begin
                if (ack_vld) begin
                    next_state = S_RESP;
                end
            end
            S_RESP: begin
                if (done) begin
                    next_state = S_IDLE;
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            req_q <= '{addr: awaddr, wr_en: 1'b1, rd_en: 1'b0, wr_data: wdata};
        end else if (rd_go) begin
            req_q <= '{addr: araddr, wr_en: 1'b0, rd_en: 1'b1, wr_data: '0};
        end
        // capture on ack, held until the master takes it
        if (state == S_WAIT && ack_vld) begin
            rdata_q <= rsp.rd_data;
            resp_q  <= rsp.err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign req     = req_q;
    assign req_vld = (state == S_REQ);
    assign bvalid  = (state == S_RESP) && req_q.wr_en;
    assign rvalid  = (state == S_RESP) && !req_q.wr_en;
    assign bresp   = resp_q;
    assign rresp   = resp_q;
    assign rdata   = rdata_q;

endmodule

`default_nettype wire

// ==== logic/reg_addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_addr_decoder (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire reg_bus_pkg::reg_req_t  req,
    input  wire                         req_vld,
    output reg_bus_pkg::reg_req_t       req_out [2],
    output logic                        req_vld_out [2],
    input  wire reg_bus_pkg::reg_rsp_t  rsp_in [2],
    input  wire                         ack_in [2],
    output reg_bus_pkg::reg_rsp_t       rsp,
    output logic                        ack_vld
);
    import reg_bus_pkg::*;

    region_t region;
    logic    hit0;
    logic    hit1;
    logic    sel_q;
    logic    miss_q;

    assign region = addr_region(req.addr);
    assign hit0   = (region == REGION_0);
    assign hit1   = (region == REGION_1);

    // payload goes to both ports, the pulse only to the matching one
    assign req_out[0]     = req;
    assign req_out[1]     = req;
    assign req_vld_out[0] = req_vld && hit0;
    assign req_vld_out[1] = req_vld && hit1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q  <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            if (req_vld) begin
                sel_q <= hit1;
            end
            // unmapped region answers itself next cycle
            miss_q <= req_vld && !hit0 && !hit1;
        end
    end

    always_comb begin
        if (miss_q) begin
            rsp.rd_data = '0;
            rsp.err     = 1'b1;
            ack_vld     = 1'b1;
        end else begin
            rsp     = rsp_in[sel_q];
            ack_vld = ack_in[sel_q];
        end
    end

endmodule

`default_nettype wire

// ==== logic/slv_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module slv_fsm (
    input  wire                         clk,
    input  wire                         rst_n,
    // upstream, from the decoder
    input  wire reg_bus_pkg::reg_req_t  up_req,
    input  wire                         up_req_vld,
    output reg_bus_pkg::reg_rsp_t       up_rsp,
    output logic                        up_ack_vld,
    // downstream, to the register region
    output reg_bus_pkg::reg_req_t       dn_req,
    output logic                        dn_req_vld,
    input  wire reg_bus_pkg::reg_rsp_t  dn_rsp,
    input  wire                         dn_ack_vld,
    input  wire                         soft_rst,
    output logic                        sync_reset
);
    import reg_bus_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_WAIT_ACK
    } state_t;

    state_t state;
    state_t next_state;
    logic   start;
    addr_t  addr_q;
    data_t  wr_data_q;
    logic   wr_en_q;
    logic   rd_en_q;
    logic   req_vld_q;

    always_comb begin
        case (state)
            S_IDLE:     next_state = (!soft_rst && up_req_vld) ? S_WAIT_ACK : S_IDLE;
            S_WAIT_ACK: next_state = (soft_rst || dn_ack_vld) ? S_IDLE : S_WAIT_ACK;
            default:    next_state = S_IDLE;
        endcase
    end

    assign start = (state == S_IDLE) && (next_state == S_WAIT_ACK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            wr_en_q    <= 1'b0;
            rd_en_q    <= 1'b0;
            req_vld_q  <= 1'b0;
            sync_reset <= 1'b0;
        end else begin
            state      <= next_state;
            // enables and pulse last one cycle only
            wr_en_q    <= start && up_req.wr_en;
            rd_en_q    <= start && up_req.rd_en;
            req_vld_q  <= start;
            sync_reset <= soft_rst;
        end
    end

    // address and data held for the whole wait
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q    <= up_req.addr;
            wr_data_q <= up_req.wr_data;
        end
    end

    always_comb begin
        if (state == S_IDLE) begin
            dn_req = '0;
        end else begin
            dn_req.addr    = addr_q;
            dn_req.wr_en   = wr_en_q;
            dn_req.rd_en   = rd_en_q;
            dn_req.wr_data = wr_data_q;
        end
    end

    assign dn_req_vld = req_vld_q;
    assign up_ack_vld = dn_ack_vld;
    assign up_rsp     = dn_ack_vld ? dn_rsp : '0;

endmodule

`default_nettype wire

// ==== logic/reg_file_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file_slave #(
    parameter int ACK_LATENCY = 2,
    parameter int NUM_REGS    = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire reg_bus_pkg::reg_req_t  req,
    input  wire                         req_vld,
    output reg_bus_pkg::reg_rsp_t       rsp,
    output logic                        ack_vld,
    input  wire                         sync_reset
);
    import reg_bus_pkg::*;

    localparam int CNT_W = $clog2(ACK_LATENCY + 1);

    data_t            regs [NUM_REGS];
    reg_req_t         req_q;
    reg_idx_t         idx;
    logic [CNT_W-1:0] cnt;

    // upper address bits ignored, words alias
    assign idx     = addr_index(req_q.addr);
    assign ack_vld = (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (req_vld) begin
            req_q <= req;
        end
    end

    // loaded on the pulse, ack when it reaches one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (req_vld) begin
            cnt <= CNT_W'(ACK_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sync_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ack_vld && req_q.wr_en) begin
            regs[idx] <= req_q.wr_data;
        end
    end

    assign rsp.rd_data = req_q.rd_en ? regs[idx] : '0;
    assign rsp.err     = 1'b0;

endmodule

`default_nettype wire

// ==== logic/reg_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_subsys_top #(
    parameter int LAT0     = 2,
    parameter int LAT1     = 5,
    parameter int NUM_REGS = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire reg_bus_pkg::addr_t     awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire reg_bus_pkg::data_t     wdata,
    input  wire                         wvalid,
    output logic                        wready,
    output reg_bus_pkg::axi_resp_t      bresp,
    output logic                        bvalid,
    input  wire                         bready,
    input  wire reg_bus_pkg::addr_t     araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output reg_bus_pkg::data_t          rdata,
    output reg_bus_pkg::axi_resp_t      rresp,
    output logic                        rvalid,
    input  wire                         rready,
    input  wire                         soft_rst
);
    import reg_bus_pkg::*;

    // bridge to decoder
    reg_req_t br_req;
    logic     br_req_vld;
    reg_rsp_t br_rsp;
    logic     br_ack_vld;

    // decoder to FSMs
    reg_req_t dec_req [2];
    logic     dec_req_vld [2];
    reg_rsp_t dec_rsp [2];
    logic     dec_ack [2];

    axil_reg_bridge u_bridge (
        .*,
        .req     (br_req),
        .req_vld (br_req_vld),
        .rsp     (br_rsp),
        .ack_vld (br_ack_vld)
    );

    reg_addr_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (br_req),
        .req_vld     (br_req_vld),
        .req_out     (dec_req),
        .req_vld_out (dec_req_vld),
        .rsp_in      (dec_rsp),
        .ack_in      (dec_ack),
        .rsp         (br_rsp),
        .ack_vld     (br_ack_vld)
    );

    for (genvar i = 0; i < 2; i++) begin : g_region
        reg_req_t rf_req;
        logic     rf_req_vld;
        reg_rsp_t rf_rsp;
        logic     rf_ack;
        logic     rf_sync_reset;

        slv_fsm u_fsm (
            .clk        (clk),
            .rst_n      (rst_n),
            .up_req     (dec_req[i]),
            .up_req_vld (dec_req_vld[i]),
            .up_rsp     (dec_rsp[i]),
            .up_ack_vld (dec_ack[i]),
            .dn_req     (rf_req),
            .dn_req_vld (rf_req_vld),
            .dn_rsp     (rf_rsp),
            .dn_ack_vld (rf_ack),
            .soft_rst   (soft_rst),
            .sync_reset (rf_sync_reset)
        );

        // region 0 answers after LAT0, region 1 after LAT1
        reg_file_slave #(
            .ACK_LATENCY ((i == 0) ? LAT0 : LAT1),
            .NUM_REGS    (NUM_REGS)
        ) u_regs (
            .clk        (clk),
            .rst_n      (rst_n),
            .req        (rf_req),
            .req_vld    (rf_req_vld),
            .rsp        (rf_rsp),
            .ack_vld    (rf_ack),
            .sync_reset (rf_sync_reset)
        );
    end

endmodule

`default_nettype wire

// ==== testbench/tb_reg_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_reg_subsys;
    import reg_bus_pkg::*;

    localparam int TIMEOUT = 200;

    typedef struct packed {
        data_t     data;
        axi_resp_t resp;
    } rd_result_t;

    logic      clk = 1'b0;
    logic      rst_n;
    addr_t     awaddr;
    logic      awvalid;
    logic      awready;
    data_t     wdata;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    addr_t     araddr;
    logic      arvalid;
    logic      arready;
    data_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    logic      soft_rst;

    integer     seed = 4;
    int         hold = 0;
    data_t      shadow [2][16];
    axi_resp_t  wr_exp [$];
    axi_resp_t  wr_got [$];
    rd_result_t rd_exp [$];
    rd_result_t rd_got [$];

    always #20 clk = ~clk;

    reg_subsys_top #(
        .LAT0     (2),
        .LAT1     (5),
        .NUM_REGS (16)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .soft_rst (soft_rst)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %h got %h", name, exp, got));
        end
    endtask

    // region in bits 15:12, word in bits 5:2, middle bits as given
    function automatic addr_t make_addr(input int region, input int idx, input int mid);
        return {region_t'(region), 6'(mid), reg_idx_t'(idx), 2'b00};
    endfunction

    function automatic rd_result_t ref_read(input addr_t addr);
        rd_result_t r;
        if (addr[15:12] > 4'd1) begin
            r.data = '0;
            r.resp = RESP_SLVERR;
        end else begin
            r.data = shadow[addr[12]][addr[5:2]];
            r.resp = RESP_OKAY;
        end
        return r;
    endfunction

    // unmapped writes leave the shadow alone
    function automatic axi_resp_t ref_write(input addr_t addr, input data_t data);
        if (addr[15:12] > 4'd1) begin
            return RESP_SLVERR;
        end
        shadow[addr[12]][addr[5:2]] = data;
        return RESP_OKAY;
    endfunction

    task automatic axi_write(input addr_t addr, input data_t data);
        axi_resp_t seen;
        int        n;
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            n++;
            if (n > TIMEOUT) abort_run("write address and data never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) abort_run("write response never arrived");
            @(negedge clk);
        end
        seen = bresp;
        // response must stay put while the master stalls
        repeat (hold) begin
            @(negedge clk);
            if (!bvalid) abort_run("bvalid dropped while bready was low");
            check_resp("bresp", seen, bresp);
        end
        @(posedge clk);
        #2;
        bready = 1'b1;
        @(posedge clk);
        #2;
        bready = 1'b0;
        wr_exp.push_back(ref_write(addr, data));
        wr_got.push_back(seen);
    endtask

    task automatic axi_read(input addr_t addr);
        rd_result_t seen;
        int         n;
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > TIMEOUT) abort_run("read address never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT) abort_run("read data never arrived");
            @(negedge clk);
        end
        seen.data = rdata;
        seen.resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            if (!rvalid) abort_run("rvalid dropped while rready was low");
            check_data("rdata", seen.data, rdata);
            check_resp("rresp", seen.resp, rresp);
        end
        @(posedge clk);
        #2;
        rready = 1'b1;
        @(posedge clk);
        #2;
        rready = 1'b0;
        rd_exp.push_back(ref_read(addr));
        rd_got.push_back(seen);
    endtask

    task automatic read_all_mapped();
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 16; i++) begin
                axi_read(make_addr(r, i, 0));
            end
        end
    endtask

    // compares results once the drivers have queued them
    always @(negedge clk) begin : compare_results
        rd_result_t e;
        rd_result_t g;
        while (wr_got.size() > 0) begin
            check_resp("bresp", wr_exp.pop_front(), wr_got.pop_front());
        end
        while (rd_got.size() > 0) begin
            e = rd_exp.pop_front();
            g = rd_got.pop_front();
            check_data("rdata", e.data, g.data);
            check_resp("rresp", e.resp, g.resp);
        end
    end

    initial begin
        int n;
        rst_n    = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        soft_rst = 1'b0;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 16; i++) begin
                shadow[r][i] = '0;
            end
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (awready || wready || arready || bvalid || rvalid) begin
            abort_run("a ready or valid output is high after reset");
        end

        // full write then readback of both regions
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 16; i++) begin
                axi_write(make_addr(r, i, 0), data_t'($random(seed)));
            end
        end
        read_all_mapped();

        // unmapped regions, then mapped words must be untouched
        for (int r = 2; r < 16; r++) begin
            axi_write(make_addr(r, r, 0), data_t'($random(seed)));
            axi_read(make_addr(r, r, 0));
        end
        read_all_mapped();

        // upper address bits within a region alias
        axi_write(make_addr(0, 3, 6'h2a), 32'h1234_abcd);
        axi_read(make_addr(0, 3, 0));
        axi_write(make_addr(1, 9, 6'h3f), 32'h5a5a_0f0f);
        axi_read(make_addr(1, 9, 6'h11));

        // stalled responses
        for (int k = 0; k < 8; k++) begin
            n = $unsigned($random(seed)) % 16;
            hold = 1 + ($unsigned($random(seed)) % 10);
            axi_write(make_addr(k % 2, n, 0), data_t'($random(seed)));
            hold = 1 + ($unsigned($random(seed)) % 10);
            axi_read(make_addr(k % 2, n, 0));
        end
        hold = 0;
        axi_read(make_addr(0, 0, 0));

        // soft reset while idle clears both regions
        @(posedge clk);
        #2;
        soft_rst = 1'b1;
        @(posedge clk);
        #2;
        soft_rst = 1'b0;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 16; i++) begin
                shadow[r][i] = '0;
            end
        end
        repeat (2) @(posedge clk);
        read_all_mapped();

        n = 0;
        while ((wr_got.size() != 0 || rd_got.size() != 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        if (wr_got.size() == 0 && rd_got.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("results were left unchecked at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/reg_bus_pkg.sv
logic/axil_reg_bridge.sv
logic/reg_addr_decoder.sv
logic/slv_fsm.sv
logic/reg_file_slave.sv
logic/reg_subsys_top.sv
testbench/tb_reg_subsys.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_reg_subsys
FILELIST = tb.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
